// ==== verilog/conv_pkg.sv ====
/*
 * Shared widths, buffer map and enums for the convolution core.
 * Buffer regions are fixed and nothing checks a load against its region's size.
 * Word byte order: element 0 in bits 31..24 on input, channel 0 in bits 7..0 on output.
 */
`default_nettype none

package conv_pkg;

  localparam int DATA_W         = 32;  // stream and buffer word
  localparam int BYTE_W         = 8;
  localparam int BYTES_PER_WORD = 4;
  localparam int PROD_W         = 16;
  localparam int ACC_W          = 28;
  localparam int ADDR_W         = 10;
  localparam int BUF_DEPTH      = 1024;
  localparam int LEN_W          = 7;   // word and channel counts

  // region start addresses
  localparam logic [ADDR_W-1:0] FEAT_BASE   = 10'd0;
  localparam logic [ADDR_W-1:0] BIAS_BASE   = 10'd64;
  localparam logic [ADDR_W-1:0] WEIGHT_BASE = 10'd128;

  // requantization
  localparam int                BIAS_SHIFT = 6;   // bias alignment, low bit of result field
  localparam int                SAT_HI_BIT = 26;
  localparam logic [BYTE_W-1:0] SAT_MAX    = 8'd127;

  typedef enum logic [1:0] {CMD_LOAD_FEAT, CMD_LOAD_WEIGHT, CMD_LOAD_BIAS, CMD_RUN} cmd_e;
  typedef enum logic [1:0] {ST_IDLE, ST_LOAD, ST_RUN} ctrl_state_e;

endpackage

`default_nettype wire

// ==== verilog/word_buffer.sv ====
/*
 * Single-port word memory, read data registered one cycle after en.
 * A write cycle does not update rdata.
 */
`timescale 1ns/1ps
`default_nettype none

module word_buffer import conv_pkg::*; (
  input  wire logic              clk,
  input  wire logic              en,
  input  wire logic              we,
  input  wire logic [ADDR_W-1:0] addr,
  input  wire logic [DATA_W-1:0] wdata,
  output logic [DATA_W-1:0]      rdata
);

  logic [DATA_W-1:0] mem [BUF_DEPTH];

  always_ff @(posedge clk) begin
    if (en) begin
      if (we) mem[addr] <= wdata;
      else    rdata     <= mem[addr];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/buf_arbiter.sv ====
/*
 * Fixed priority on the buffer port: loader, MAC engine, requantizer.
 * Read data comes back one cycle after the grant on the shared rdata.
 */
`timescale 1ns/1ps
`default_nettype none

module buf_arbiter import conv_pkg::*; (
  input  wire logic              clk,
  input  wire logic              rstn,
  input  wire logic              ld_req,
  input  wire logic              ld_we,
  input  wire logic [ADDR_W-1:0] ld_addr,
  input  wire logic [DATA_W-1:0] ld_wdata,
  input  wire logic              mac_req,
  input  wire logic [ADDR_W-1:0] mac_addr,
  input  wire logic              rq_req,
  input  wire logic [ADDR_W-1:0] rq_addr,
  input  wire logic [DATA_W-1:0] mem_rdata,
  output logic                   ld_gnt,
  output logic                   mac_gnt,
  output logic                   mac_rvalid,
  output logic                   rq_gnt,
  output logic                   rq_rvalid,
  output logic                   mem_en,
  output logic                   mem_we,
  output logic [ADDR_W-1:0]      mem_addr,
  output logic [DATA_W-1:0]      mem_wdata,
  output logic [DATA_W-1:0]      rdata
);

  assign ld_gnt  = ld_req;
  assign mac_gnt = mac_req && !ld_req;
  assign rq_gnt  = rq_req && !ld_req && !mac_req;

  assign mem_en    = ld_req || mac_req || rq_req;
  assign mem_we    = ld_gnt && ld_we;  // only the loader writes
  assign mem_addr  = ld_req ? ld_addr : (mac_req ? mac_addr : rq_addr);
  assign mem_wdata = ld_wdata;
  assign rdata     = mem_rdata;

  // winner of the previous cycle owns this cycle's read data
  always_ff @(posedge clk) begin
    if (!rstn) begin
      mac_rvalid <= 1'b0;
      rq_rvalid  <= 1'b0;
    end else begin
      mac_rvalid <= mac_gnt;
      rq_rvalid  <= rq_gnt;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/stream_loader.sv ====
/*
 * Writes load_count stream words to consecutive buffer addresses.
 * Relies on top arbiter priority, so a handshake is always a write.
 */
`timescale 1ns/1ps
`default_nettype none

module stream_loader import conv_pkg::*; (
  input  wire logic                clk,
  input  wire logic                rstn,
  input  wire logic                load_start,
  input  wire logic [ADDR_W-1:0]   load_base,
  input  wire logic [2*LEN_W-1:0]  load_count,
  input  wire logic [DATA_W-1:0]   s_tdata,
  input  wire logic                s_tvalid,
  input  wire logic                gnt,
  output logic                     s_tready,
  output logic                     req,
  output logic                     we,
  output logic [ADDR_W-1:0]        addr,
  output logic [DATA_W-1:0]        wdata,
  output logic                     load_done
);

  logic [2*LEN_W-1:0] remain;  // words still to accept
  logic               accept;
  logic               last;

  assign req       = s_tvalid & s_tready;
  assign we        = req;
  assign wdata     = s_tdata;
  assign accept    = req & gnt;
  assign last      = (remain == (2*LEN_W)'(1));
  assign load_done = accept & last;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      s_tready <= 1'b0;
      remain   <= '0;
      addr     <= '0;
    end else if (load_start) begin
      s_tready <= 1'b1;
      remain   <= load_count;
      addr     <= load_base;
    end else if (accept) begin
      addr   <= addr + 1'b1;
      remain <= remain - 1'b1;
      if (last) s_tready <= 1'b0;  // close the stream on the final word
    end
  end

endmodule

`default_nettype wire

// ==== verilog/conv_ctrl.sv ====
/*
 * Command decode and sequencing. A command is decoded the cycle start is seen;
 * load sizes come from num_words and num_outch at that moment.
 * done is a one-cycle pulse and busy falls with it.
 */
`timescale 1ns/1ps
`default_nettype none

module conv_ctrl import conv_pkg::*; (
  input  wire logic             clk,
  input  wire logic             rstn,
  input  wire cmd_e             cmd,
  input  wire logic             start,
  input  wire logic [LEN_W-1:0] num_words,
  input  wire logic [LEN_W-1:0] num_outch,
  input  wire logic             load_done,
  input  wire logic             out_done,
  output logic                  load_start,
  output logic [ADDR_W-1:0]     load_base,
  output logic [2*LEN_W-1:0]    load_count,
  output logic                  run_start,
  output logic [LEN_W-1:0]      run_words,
  output logic [LEN_W-1:0]      run_outch,
  output logic                  busy,
  output logic                  done
);

  ctrl_state_e state;
  logic        take;

  assign take = (state == ST_IDLE) && start;
  assign busy = (state != ST_IDLE);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state      <= ST_IDLE;
      load_start <= 1'b0;
      run_start  <= 1'b0;
      done       <= 1'b0;
    end else begin
      load_start <= 1'b0;  // pulses by default
      run_start  <= 1'b0;
      done       <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (start) begin
            if (cmd == CMD_RUN) begin
              state     <= ST_RUN;
              run_start <= 1'b1;
            end else begin
              state      <= ST_LOAD;
              load_start <= 1'b1;
            end
          end
        end
        ST_LOAD: begin
          if (load_done) begin
            state <= ST_IDLE;
            done  <= 1'b1;
          end
        end
        ST_RUN: begin
          if (out_done) begin
            state <= ST_IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // configuration held for the whole operation
  always_ff @(posedge clk) begin
    if (take) begin
      run_words <= num_words;
      run_outch <= num_outch;
      case (cmd)
        CMD_LOAD_WEIGHT: begin
          load_base  <= WEIGHT_BASE;
          load_count <= (2*LEN_W)'(num_words) * (2*LEN_W)'(num_outch);
        end
        CMD_LOAD_BIAS: begin
          load_base  <= BIAS_BASE;
          load_count <= (2*LEN_W)'(num_outch >> $clog2(BYTES_PER_WORD));  // 4 per word
        end
        default: begin
          load_base  <= FEAT_BASE;
          load_count <= (2*LEN_W)'(num_words);
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mac_engine.sv ====
/*
 * Per output channel, reads each feature word and its weight word and runs the
 * four byte pairs through a 3-stage signed multiplier and a 28-bit accumulator.
 * A channel starts only while acc_ready is high.
 */
`timescale 1ns/1ps
`default_nettype none

module mac_engine import conv_pkg::*; (
  input  wire logic              clk,
  input  wire logic              rstn,
  input  wire logic              run_start,
  input  wire logic [LEN_W-1:0]  run_words,
  input  wire logic [LEN_W-1:0]  run_outch,
  input  wire logic              gnt,
  input  wire logic              rvalid,
  input  wire logic [DATA_W-1:0] rdata,
  input  wire logic              acc_ready,
  output logic                   req,
  output logic [ADDR_W-1:0]      addr,
  output logic                   acc_valid,
  output logic [ACC_W-1:0]       acc,
  output logic [LEN_W-1:0]       acc_chan,
  output logic                   acc_last
);

  typedef enum logic [2:0] {MS_IDLE, MS_START, MS_FEAT, MS_WGT, MS_FEED, MS_DRAIN} mac_state_e;

  mac_state_e                           state;
  logic                                 pend;      // read granted, data not back yet
  logic [LEN_W-1:0]                     word_idx, chan;
  logic [ADDR_W-1:0]                    wgt_addr;
  logic [$clog2(BYTES_PER_WORD)-1:0]    byte_cnt;
  logic [DATA_W-1:0]                    feat_q, wgt_q;
  logic                                 feeding, last_chan;
  logic [BYTE_W-1:0]                    a_in, b_in;

  // multiplier pipeline
  logic              v1, v2, v3, f1, f2, f3, s1, s2;
  logic [BYTE_W-1:0] a_mag, b_mag;
  logic [PROD_W-1:0] prod_u, prod_s;

  assign feeding   = (state == MS_FEED);
  assign last_chan = (chan == run_outch - 1'b1);
  assign a_in      = feat_q[DATA_W-1 -: BYTE_W];  // element 0 sits in the top byte
  assign b_in      = wgt_q[DATA_W-1 -: BYTE_W];
  assign req       = ((state == MS_FEAT) || (state == MS_WGT)) && !pend;
  assign addr      = (state == MS_FEAT) ? FEAT_BASE + ADDR_W'(word_idx) : wgt_addr;

  //////////////////////////////////////////////////////////////
  // sequencer
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state     <= MS_IDLE;
      pend      <= 1'b0;
      acc_valid <= 1'b0;
      chan      <= '0;
      word_idx  <= '0;
      byte_cnt  <= '0;
      wgt_addr  <= WEIGHT_BASE;
    end else begin
      acc_valid <= 1'b0;
      case (state)
        MS_IDLE: begin
          if (run_start) begin
            state    <= MS_START;
            chan     <= '0;
            wgt_addr <= WEIGHT_BASE;  // channels follow each other in the buffer
          end
        end
        MS_START: begin
          if (acc_ready && !acc_valid) begin  // packer has taken the previous result
            state    <= MS_FEAT;
            word_idx <= '0;
          end
        end
        MS_FEAT, MS_WGT: begin
          if (gnt) pend <= 1'b1;
          if (rvalid) begin
            pend <= 1'b0;
            if (state == MS_FEAT) begin
              state <= MS_WGT;
            end else begin
              state    <= MS_FEED;
              byte_cnt <= '0;
              wgt_addr <= wgt_addr + 1'b1;
            end
          end
        end
        MS_FEED: begin
          byte_cnt <= byte_cnt + 1'b1;
          if (byte_cnt == BYTES_PER_WORD - 1) begin
            if (word_idx == run_words - 1'b1) begin
              state <= MS_DRAIN;
            end else begin
              word_idx <= word_idx + 1'b1;
              state    <= MS_FEAT;
            end
          end
        end
        MS_DRAIN: begin
          if (!(v1 || v2 || v3)) begin  // last product is in acc
            acc_valid <= 1'b1;
            acc_chan  <= chan;
            acc_last  <= last_chan;
            chan      <= chan + 1'b1;
            state     <= last_chan ? MS_IDLE : MS_START;
          end
        end
        default: state <= MS_IDLE;
      endcase
    end
  end

  // word registers shift one byte pair out per feed cycle
  always_ff @(posedge clk) begin
    if (rvalid && state == MS_FEAT) begin
      feat_q <= rdata;
    end else if (rvalid && state == MS_WGT) begin
      wgt_q <= rdata;
    end else if (feeding) begin
      feat_q <= feat_q << BYTE_W;
      wgt_q  <= wgt_q << BYTE_W;
    end
  end

  //////////////////////////////////////////////////////////////
  // signed multiply and accumulate
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      v1 <= 1'b0;
      v2 <= 1'b0;
      v3 <= 1'b0;
    end else begin
      v1 <= feeding;
      v2 <= v1;
      v3 <= v2;
    end
  end

  always_ff @(posedge clk) begin
    a_mag  <= a_in[BYTE_W-1] ? -a_in : a_in;   // -128 gives 128 unsigned
    b_mag  <= b_in[BYTE_W-1] ? -b_in : b_in;
    s1     <= a_in[BYTE_W-1] ^ b_in[BYTE_W-1];
    f1     <= (word_idx == '0) && (byte_cnt == '0);
    prod_u <= PROD_W'(a_mag) * PROD_W'(b_mag);
    s2     <= s1;
    f2     <= f1;
    prod_s <= s2 ? -prod_u : prod_u;
    f3     <= f2;
    if (v3) acc <= (f3 ? '0 : acc) + {{(ACC_W-PROD_W){prod_s[PROD_W-1]}}, prod_s};
  end

endmodule

`default_nettype wire

// ==== verilog/requant_packer.sv ====
/*
 * Adds the channel bias, clamps to 0..127 and packs four results per word.
 * One result is handled at a time; acc_ready is low while busy or holding a word.
 */
`timescale 1ns/1ps
`default_nettype none

module requant_packer import conv_pkg::*; (
  input  wire logic              clk,
  input  wire logic              rstn,
  input  wire logic              acc_valid,
  input  wire logic [ACC_W-1:0]  acc,
  input  wire logic [LEN_W-1:0]  acc_chan,
  input  wire logic              acc_last,
  input  wire logic              gnt,
  input  wire logic              rvalid,
  input  wire logic [DATA_W-1:0] rdata,
  input  wire logic              m_tready,
  output logic                   acc_ready,
  output logic                   req,
  output logic [ADDR_W-1:0]      addr,
  output logic [DATA_W-1:0]      m_tdata,
  output logic                   m_tvalid,
  output logic                   m_tlast,
  output logic                   out_done
);

  typedef enum logic [2:0] {PQ_IDLE, PQ_REQ, PQ_WAIT, PQ_ADD, PQ_SEND} pq_state_e;

  localparam int LANE_W = $clog2(BYTES_PER_WORD);
  localparam int TOP    = BIAS_SHIFT + BYTE_W - 1;  // first bit above the result field

  pq_state_e         state;
  logic [ACC_W-1:0]  acc_q, sum;
  logic [LEN_W-1:0]  chan_q;
  logic              last_q;
  logic [BYTE_W-1:0] bias_q, res;
  logic [LANE_W-1:0] lane;

  assign lane      = chan_q[LANE_W-1:0];
  assign acc_ready = (state == PQ_IDLE);
  assign req       = (state == PQ_REQ);
  assign addr      = BIAS_BASE + ADDR_W'(chan_q >> LANE_W);
  assign out_done  = m_tvalid & m_tready & m_tlast;

  assign sum = acc_q + {{(ACC_W-BYTE_W-BIAS_SHIFT){bias_q[BYTE_W-1]}}, bias_q,
                        {BIAS_SHIFT{1'b0}}};

  always_comb begin
    if (sum[ACC_W-1])                res = '0;       // negative
    else if (|sum[SAT_HI_BIT:TOP])   res = SAT_MAX;  // too large
    else                             res = {1'b0, sum[TOP-1:BIAS_SHIFT]};
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state    <= PQ_IDLE;
      m_tvalid <= 1'b0;
      m_tlast  <= 1'b0;
    end else begin
      case (state)
        PQ_IDLE: if (acc_valid) state <= PQ_REQ;
        PQ_REQ:  if (gnt) state <= PQ_WAIT;   // addr held until granted
        PQ_WAIT: if (rvalid) state <= PQ_ADD;
        PQ_ADD: begin
          if (lane == LANE_W'(BYTES_PER_WORD - 1)) begin
            state    <= PQ_SEND;
            m_tvalid <= 1'b1;
            m_tlast  <= last_q;
          end else begin
            state <= PQ_IDLE;
          end
        end
        PQ_SEND: begin
          if (m_tready) begin
            state    <= PQ_IDLE;
            m_tvalid <= 1'b0;
            m_tlast  <= 1'b0;
          end
        end
        default: state <= PQ_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (acc_valid && state == PQ_IDLE) begin
      acc_q  <= acc;
      chan_q <= acc_chan;
      last_q <= acc_last;
    end
    if (rvalid && state == PQ_WAIT) bias_q <= rdata[DATA_W-1-BYTE_W*lane -: BYTE_W];
    if (state == PQ_ADD) m_tdata[BYTE_W*lane +: BYTE_W] <= res;  // channel 0 in low byte
  end

endmodule

`default_nettype wire

// ==== verilog/conv_top.sv ====
/*
 * Convolution core top level. start is taken only while busy is low.
 * num_outch must be a multiple of 4 and every count nonzero.
 */
`timescale 1ns/1ps
`default_nettype none

module conv_top import conv_pkg::*; (
  input  wire logic              clk,
  input  wire logic              rstn,
  input  wire cmd_e              cmd,
  input  wire logic              start,
  input  wire logic [LEN_W-1:0]  num_words,
  input  wire logic [LEN_W-1:0]  num_outch,
  input  wire logic [DATA_W-1:0] s_tdata,
  input  wire logic              s_tvalid,
  output logic                   s_tready,
  output logic [DATA_W-1:0]      m_tdata,
  output logic                   m_tvalid,
  input  wire logic              m_tready,
  output logic                   m_tlast,
  output logic                   busy,
  output logic                   done
);

  logic                 load_start, load_done, run_start, out_done;
  logic [ADDR_W-1:0]    load_base;
  logic [2*LEN_W-1:0]   load_count;
  logic [LEN_W-1:0]     run_words, run_outch;

  // buffer side
  logic                 ld_req, ld_we, ld_gnt;
  logic [ADDR_W-1:0]    ld_addr, mac_addr, rq_addr, mem_addr;
  logic [DATA_W-1:0]    ld_wdata, mem_wdata, mem_rdata, rdata;
  logic                 mac_req, mac_gnt, mac_rvalid;
  logic                 rq_req, rq_gnt, rq_rvalid;
  logic                 mem_en, mem_we;

  // mac to requantizer
  logic                 acc_valid, acc_ready, acc_last;
  logic [ACC_W-1:0]     acc;
  logic [LEN_W-1:0]     acc_chan;

  conv_ctrl u_ctrl (
    .clk, .rstn, .cmd, .start, .num_words, .num_outch, .load_done, .out_done,
    .load_start, .load_base, .load_count, .run_start, .run_words, .run_outch,
    .busy, .done
  );

  stream_loader u_loader (
    .clk, .rstn, .load_start, .load_base, .load_count, .s_tdata, .s_tvalid,
    .gnt(ld_gnt), .s_tready, .req(ld_req), .we(ld_we), .addr(ld_addr),
    .wdata(ld_wdata), .load_done
  );

  mac_engine u_mac (
    .clk, .rstn, .run_start, .run_words, .run_outch, .gnt(mac_gnt),
    .rvalid(mac_rvalid), .rdata, .acc_ready, .req(mac_req), .addr(mac_addr),
    .acc_valid, .acc, .acc_chan, .acc_last
  );

  requant_packer u_requant (
    .clk, .rstn, .acc_valid, .acc, .acc_chan, .acc_last, .gnt(rq_gnt),
    .rvalid(rq_rvalid), .rdata, .m_tready, .acc_ready, .req(rq_req),
    .addr(rq_addr), .m_tdata, .m_tvalid, .m_tlast, .out_done
  );

  buf_arbiter u_arb (
    .clk, .rstn, .ld_req, .ld_we, .ld_addr, .ld_wdata, .mac_req, .mac_addr,
    .rq_req, .rq_addr, .mem_rdata, .ld_gnt, .mac_gnt, .mac_rvalid, .rq_gnt,
    .rq_rvalid, .mem_en, .mem_we, .mem_addr, .mem_wdata, .rdata
  );

  word_buffer u_buf (
    .clk, .en(mem_en), .we(mem_we), .addr(mem_addr), .wdata(mem_wdata),
    .rdata(mem_rdata)
  );

endmodule

`default_nettype wire

// ==== test/conv_checker.sv ====
/*
 * Stream and status assertions for conv_top, attached by bind.
 * All properties are ignored while rstn is low.
 */
`timescale 1ns/1ps
`default_nettype none

module conv_checker import conv_pkg::*; (
  input wire logic              clk,
  input wire logic              rstn,
  input wire logic              s_tready,
  input wire logic              m_tvalid,
  input wire logic              m_tready,
  input wire logic              m_tlast,
  input wire logic              busy,
  input wire logic              done,
  input wire logic [DATA_W-1:0] m_tdata
);

  // output word must hold while the sink stalls
  a_out_hold: assert property (@(posedge clk) disable iff (!rstn)
    m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata))
    else $error("m_tvalid or m_tdata changed while m_tready was low");

  a_idle_quiet: assert property (@(posedge clk) disable iff (!rstn)
    !busy |-> !s_tready && !m_tvalid)  // no stream activity when idle
    else $error("stream handshake signal high while not busy");

  // run ends with a single done right after the last word is taken
  a_done_pulse: assert property (@(posedge clk) disable iff (!rstn)
    m_tvalid && m_tready && m_tlast |=> done ##1 !done)
    else $error("done missing or longer than one cycle after the last output word");

endmodule

bind conv_top conv_checker u_checker (
  .clk, .rstn, .s_tready, .m_tvalid, .m_tready, .m_tlast, .busy, .done, .m_tdata
);

`default_nettype wire

// ==== test/conv_tb.sv ====
/*
 * Table-driven testbench for conv_top; expected words come from a model of the
 * dot product, bias and requantization rules kept in this file.
 * Rows must fit the buffer regions: 64 feature words, 896 weight words.
 */
`timescale 1ns/1ps
`default_nettype none

module conv_tb import conv_pkg::*; ();

  localparam int NUM_TESTS  = 5;
  localparam int MODE_RAND  = 0;  // mixed results
  localparam int MODE_NEG   = 1;  // every product negative
  localparam int MODE_LARGE = 2;  // saturating sums

  // case table, one column per array
  string names [NUM_TESTS] = '{"rand_small", "rand_wide", "all_negative",
                               "saturate", "rand_deep"};
  int    words_t [NUM_TESTS] = '{2, 8, 4, 3, 16};
  int    outch_t [NUM_TESTS] = '{4, 16, 8, 8, 12};
  int    mode_t  [NUM_TESTS] = '{MODE_RAND, MODE_RAND, MODE_NEG, MODE_LARGE, MODE_RAND};
  bit    rdy_rand[NUM_TESTS] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1};  // random m_tready

  logic              clk, rstn, start, s_tvalid, s_tready;
  logic              m_tvalid, m_tready, m_tlast, busy, done;
  cmd_e              cmd;
  logic [LEN_W-1:0]  num_words, num_outch;
  logic [DATA_W-1:0] s_tdata, m_tdata;

  logic [DATA_W-1:0] feat [64];
  logic [DATA_W-1:0] wgt [896];
  logic [DATA_W-1:0] bias_w [32];
  logic [DATA_W-1:0] stream_q [$];
  string             test_name;
  int                errors, nw, no;
  bit                cur_rdy;

  conv_top dut (
    .clk, .rstn, .cmd, .start, .num_words, .num_outch, .s_tdata, .s_tvalid,
    .s_tready, .m_tdata, .m_tvalid, .m_tready, .m_tlast, .busy, .done
  );

  always #2 clk = ~clk;

  initial begin : watchdog
    int budget;
    budget = 0;
    for (int r = 0; r < NUM_TESTS; r++) begin
      budget += words_t[r] + outch_t[r] / 4 + 2 * words_t[r] * outch_t[r];
    end
    repeat (16 + 40 * budget + 500) @(posedge clk);
    $display("watchdog expired: run not finished after %0d words of work", budget);
    $display("TEST FAIL");
    $fatal(1, "timeout");
  end

  task automatic check(string what, logic [DATA_W-1:0] expected, logic [DATA_W-1:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "mismatch");
    end
  endtask

  //////////////////////////////////////////////////////////////
  // stimulus data and reference model
  //////////////////////////////////////////////////////////////

  function automatic logic [BYTE_W-1:0] gen_byte(int mode, int kind);  // kind 0 feat, 1 wgt, 2 bias
    int v;
    if (mode == MODE_NEG) begin
      if (kind == 0)      v = 64 + $urandom % 64;
      else if (kind == 1) v = -(64 + $urandom % 65);   // -64..-128
      else                v = -(1 + $urandom % 128);
    end else if (mode == MODE_LARGE) begin
      v = (kind == 2) ? $urandom % 128 : 64 + $urandom % 64;
    end else begin
      v = (kind == 1) ? int'($urandom % 32) - 16 : $urandom % 256;  // small weights
    end
    return v[BYTE_W-1:0];
  endfunction

  function automatic logic [DATA_W-1:0] make_word(int mode, int kind);
    return {gen_byte(mode, kind), gen_byte(mode, kind), gen_byte(mode, kind),
            gen_byte(mode, kind)};
  endfunction

  // element 0 sits in the top byte
  function automatic int elem(logic [DATA_W-1:0] word, int idx);
    return int'($signed(word[DATA_W-1-BYTE_W*idx -: BYTE_W]));
  endfunction

  function automatic logic [BYTE_W-1:0] requant(int total);
    if (total < 0) return 8'd0;
    if (total[26:13] != 0) return 8'd127;
    return {1'b0, total[12:6]};
  endfunction

  function automatic logic [DATA_W-1:0] expected_word(int w);
    logic [DATA_W-1:0] word;
    int ch, sum;
    for (int l = 0; l < 4; l++) begin
      ch  = 4 * w + l;
      sum = elem(bias_w[ch / 4], ch % 4) * 64;
      for (int i = 0; i < nw; i++) begin
        for (int b = 0; b < 4; b++) sum += elem(feat[i], b) * elem(wgt[ch * nw + i], b);
      end
      word[BYTE_W*l +: BYTE_W] = requant(sum);  // channel 0 in bits 7..0
    end
    return word;
  endfunction

  //////////////////////////////////////////////////////////////
  // bus tasks
  //////////////////////////////////////////////////////////////

  task automatic send_load(cmd_e c);
    cmd   = c;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    for (int i = 0; i < stream_q.size(); i++) begin
      s_tdata  = stream_q[i];
      s_tvalid = 1'b1;
      check($sformatf("done before word %0d", i), 32'd0, done);
      while (!s_tready) @(negedge clk);
      @(negedge clk);  // word taken on the edge between
    end
    s_tvalid = 1'b0;
    check("load done", 32'd1, done);
    check("s_tready after load", 32'd0, s_tready);
    @(negedge clk);
    check("done pulse width", 32'd0, done);
    check("busy after load", 32'd0, busy);
  endtask

  task automatic run_and_compare();
    int idx, n_out;
    idx   = 0;
    n_out = no / 4;
    cmd   = CMD_RUN;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    while (idx < n_out) begin
      m_tready = cur_rdy ? 1'($urandom % 2) : 1'b1;
      check("done during run", 32'd0, done);
      if (m_tvalid && m_tready) begin
        check($sformatf("word %0d data", idx), expected_word(idx), m_tdata);
        check($sformatf("word %0d tlast", idx), 32'(idx == n_out - 1), m_tlast);
        idx++;
      end
      @(negedge clk);
    end
    m_tready = 1'b0;
    check("run done", 32'd1, done);
    check("busy after run", 32'd0, busy);
  endtask

  initial begin
    void'($urandom(32'h5b6b));
    clk = 1'b0; rstn = 1'b0;
    start = 1'b0;
    cmd = CMD_LOAD_FEAT;
    num_words = '0;
    num_outch = '0;
    s_tdata = '0;
    s_tvalid = 1'b0;
    m_tready = 1'b0;
    errors = 0;
    test_name = "reset";
    repeat (16) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    check("s_tready", 32'd0, s_tready);
    check("m_tvalid", 32'd0, m_tvalid);
    check("busy", 32'd0, busy);
    check("done", 32'd0, done);
    for (int r = 0; r < NUM_TESTS; r++) begin
      test_name = names[r];
      nw        = words_t[r];
      no        = outch_t[r];
      cur_rdy   = rdy_rand[r];
      num_words = LEN_W'(nw);
      num_outch = LEN_W'(no);
      for (int i = 0; i < nw; i++) feat[i] = make_word(mode_t[r], 0);
      for (int i = 0; i < nw * no; i++) wgt[i] = make_word(mode_t[r], 1);
      for (int i = 0; i < no / 4; i++) bias_w[i] = make_word(mode_t[r], 2);
      stream_q.delete();
      for (int i = 0; i < nw; i++) stream_q.push_back(feat[i]);
      send_load(CMD_LOAD_FEAT);
      stream_q.delete();
      for (int i = 0; i < no / 4; i++) stream_q.push_back(bias_w[i]);
      send_load(CMD_LOAD_BIAS);
      stream_q.delete();
      for (int i = 0; i < nw * no; i++) stream_q.push_back(wgt[i]);
      send_load(CMD_LOAD_WEIGHT);
      run_and_compare();
    end
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
verilog/conv_pkg.sv
verilog/word_buffer.sv
verilog/buf_arbiter.sv
verilog/stream_loader.sv
verilog/conv_ctrl.sv
verilog/mac_engine.sv
verilog/requant_packer.sv
verilog/conv_top.sv
test/conv_checker.sv
test/conv_tb.sv

// ==== Makefile ====
# Verilator build and run for the convolution core testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module conv_tb -Mdir obj_dir -o conv_tb

# the run passes only if the testbench printed its pass line
run: compile
	@out="$$(./obj_dir/conv_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
